// ==== Bender.yml ====
package:
  name: mips_decode

sources:
  - hdl/isa_pkg.sv
  - hdl/pipe_pkg.sv
  - hdl/hs_stage.sv
  - hdl/inst_decoder.sv
  - hdl/operand_select.sv
  - hdl/decode_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_decode.sv

// ==== compile.f ====
+incdir+sim
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/hs_stage.sv
hdl/inst_decoder.sv
hdl/operand_select.sv
hdl/decode_top.sv
sim/tb_decode.sv

// ==== hdl/decode_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module decode_top (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                fetch_req,
    output logic                fetch_ack,
    input  pipe_pkg::fetch_t    fetch,
    output pipe_pkg::rf_read_t  rf_rd1,
    input  isa_pkg::word_t      rf_data1,
    output pipe_pkg::rf_read_t  rf_rd2,
    input  isa_pkg::word_t      rf_data2,
    input  pipe_pkg::fwd_t      ex_fwd,
    input  pipe_pkg::fwd_t      mem_fwd,
    output logic                issue_req,
    input  logic                issue_ack,
    output pipe_pkg::decoded_t  issue
);

    pipe_pkg::fetch_t    f_held;
    logic                f_req;
    logic                f_ack;
    pipe_pkg::dec_ctrl_t ctrl;
    isa_pkg::word_t      imm;
    isa_pkg::word_t      src1;
    isa_pkg::word_t      src2;
    pipe_pkg::decoded_t  dec_bundle;

    hs_stage #(
        .payload_t (pipe_pkg::fetch_t)
    ) f_stage (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_req   (fetch_req),
        .in_ack   (fetch_ack),
        .in_data  (fetch),
        .out_req  (f_req),
        .out_ack  (f_ack),
        .out_data (f_held)
    );

    inst_decoder u_decoder (
        .fetch (f_held),
        .ctrl  (ctrl),
        .rd1   (rf_rd1),
        .rd2   (rf_rd2),
        .imm   (imm)
    );

    operand_select src1_sel (
        .rd      (rf_rd1),
        .rf_data (rf_data1),
        .imm     (imm),
        .ex_fwd  (ex_fwd),
        .mem_fwd (mem_fwd),
        .operand (src1)
    );

    operand_select src2_sel (
        .rd      (rf_rd2),
        .rf_data (rf_data2),
        .imm     (imm),
        .ex_fwd  (ex_fwd),
        .mem_fwd (mem_fwd),
        .operand (src2)
    );

    // sampled by s_stage on its capture edge
    assign dec_bundle = '{ctrl: ctrl, pc: f_held.pc, src1: src1, src2: src2};

    hs_stage #(
        .payload_t (pipe_pkg::decoded_t)
    ) s_stage (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_req   (f_req),
        .in_ack   (f_ack),
        .in_data  (dec_bundle),
        .out_req  (issue_req),
        .out_ack  (issue_ack),
        .out_data (issue)
    );

endmodule

`default_nettype wire

// ==== hdl/hs_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module hs_stage #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     in_req,
    output logic     in_ack,
    input  payload_t in_data,
    output logic     out_req,
    input  logic     out_ack,
    output payload_t out_data
);

    logic     full_q;
    logic     ack_q;
    logic     drain_q;
    payload_t data_q;
    logic     capture;
    logic     release_out;

    // new entry only once both links are back to idle
    assign capture     = in_req && !ack_q && !full_q && !drain_q;
    assign release_out = full_q && out_ack;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            full_q  <= 1'b0;
            ack_q   <= 1'b0;
            drain_q <= 1'b0;
        end else begin
            if (capture) begin
                ack_q <= 1'b1;
            end else if (!in_req) begin
                ack_q <= 1'b0;
            end

            if (capture) begin
                full_q <= 1'b1;
            end else if (release_out) begin
                full_q <= 1'b0;
            end

            // hold off until downstream drops its ack
            if (release_out) begin
                drain_q <= 1'b1;
            end else if (!out_ack) begin
                drain_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            data_q <= in_data;
        end
    end

    assign in_ack   = ack_q;
    assign out_req  = full_q;
    assign out_data = data_q;

    req_held: assert property (@(posedge clk) disable iff (!arst_n)
        out_req && !out_ack |=> out_req);

    data_stable: assert property (@(posedge clk) disable iff (!arst_n)
        out_req |=> !out_req || $stable(out_data));

    ack_after_req: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(in_ack) |-> $past(in_req));

endmodule

`default_nettype wire

// ==== hdl/inst_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module inst_decoder (
    input  pipe_pkg::fetch_t    fetch,
    output pipe_pkg::dec_ctrl_t ctrl,
    output pipe_pkg::rf_read_t  rd1,
    output pipe_pkg::rf_read_t  rd2,
    output isa_pkg::word_t      imm
);

    logic [isa_pkg::op_w-1:0]    opcode;
    logic [isa_pkg::op_w-1:0]    funct;
    isa_pkg::reg_addr_t          rs;
    isa_pkg::reg_addr_t          rt;
    isa_pkg::reg_addr_t          rd;
    isa_pkg::reg_addr_t          shamt;
    logic [isa_pkg::imm_w-1:0]   imm16;

    isa_pkg::alu_op_e  op_d;
    isa_pkg::alu_sel_e sel_d;
    isa_pkg::word_t    imm_d;
    logic              reg_form;
    logic              shift_form;
    logic              imm_form;
    logic              reg_ok;
    logic              shift_ok;
    logic              legal;

    assign opcode = fetch.inst[isa_pkg::op_lsb +: isa_pkg::op_w];
    assign funct  = fetch.inst[isa_pkg::fn_lsb +: isa_pkg::op_w];
    assign rs     = fetch.inst[isa_pkg::rs_lsb +: isa_pkg::reg_addr_w];
    assign rt     = fetch.inst[isa_pkg::rt_lsb +: isa_pkg::reg_addr_w];
    assign rd     = fetch.inst[isa_pkg::rd_lsb +: isa_pkg::reg_addr_w];
    assign shamt  = fetch.inst[isa_pkg::sa_lsb +: isa_pkg::reg_addr_w];
    assign imm16  = fetch.inst[isa_pkg::imm_w-1:0];

    always_comb begin
        op_d       = isa_pkg::alu_nop;
        sel_d      = isa_pkg::sel_nop;
        imm_d      = '0;
        reg_form   = 1'b0;
        shift_form = 1'b0;
        imm_form   = 1'b0;
        case (opcode)
            isa_pkg::op_special: begin
                // register forms set reg_form, immediate shifts set shift_form
                reg_form = 1'b1;
                case (funct)
                    isa_pkg::fn_and:  {op_d, sel_d} = {isa_pkg::alu_and, isa_pkg::sel_logic};
                    isa_pkg::fn_or:   {op_d, sel_d} = {isa_pkg::alu_or, isa_pkg::sel_logic};
                    isa_pkg::fn_xor:  {op_d, sel_d} = {isa_pkg::alu_xor, isa_pkg::sel_logic};
                    isa_pkg::fn_nor:  {op_d, sel_d} = {isa_pkg::alu_nor, isa_pkg::sel_logic};
                    isa_pkg::fn_sllv: {op_d, sel_d} = {isa_pkg::alu_sll, isa_pkg::sel_shift};
                    isa_pkg::fn_srlv: {op_d, sel_d} = {isa_pkg::alu_srl, isa_pkg::sel_shift};
                    isa_pkg::fn_srav: {op_d, sel_d} = {isa_pkg::alu_sra, isa_pkg::sel_shift};
                    isa_pkg::fn_add:  {op_d, sel_d} = {isa_pkg::alu_add, isa_pkg::sel_arith};
                    isa_pkg::fn_addu: {op_d, sel_d} = {isa_pkg::alu_addu, isa_pkg::sel_arith};
                    isa_pkg::fn_sub:  {op_d, sel_d} = {isa_pkg::alu_sub, isa_pkg::sel_arith};
                    isa_pkg::fn_subu: {op_d, sel_d} = {isa_pkg::alu_subu, isa_pkg::sel_arith};
                    isa_pkg::fn_slt:  {op_d, sel_d} = {isa_pkg::alu_slt, isa_pkg::sel_arith};
                    isa_pkg::fn_sltu: {op_d, sel_d} = {isa_pkg::alu_sltu, isa_pkg::sel_arith};
                    isa_pkg::fn_sll,
                    isa_pkg::fn_srl,
                    isa_pkg::fn_sra: begin
                        reg_form   = 1'b0;
                        shift_form = 1'b1;
                        sel_d      = isa_pkg::sel_shift;
                        if (funct == isa_pkg::fn_sll) begin
                            op_d = isa_pkg::alu_sll;
                        end else if (funct == isa_pkg::fn_srl) begin
                            op_d = isa_pkg::alu_srl;
                        end else begin
                            op_d = isa_pkg::alu_sra;
                        end
                    end
                    default: reg_form = 1'b0;
                endcase
            end
            isa_pkg::op_andi: begin
                {op_d, sel_d} = {isa_pkg::alu_and, isa_pkg::sel_logic};
                imm_form      = 1'b1;
                imm_d         = {16'h0, imm16};
            end
            isa_pkg::op_ori: begin
                {op_d, sel_d} = {isa_pkg::alu_or, isa_pkg::sel_logic};
                imm_form      = 1'b1;
                imm_d         = {16'h0, imm16};
            end
            isa_pkg::op_xori: begin
                {op_d, sel_d} = {isa_pkg::alu_xor, isa_pkg::sel_logic};
                imm_form      = 1'b1;
                imm_d         = {16'h0, imm16};
            end
            isa_pkg::op_lui: begin
                // lui is an or with the upper-placed field
                {op_d, sel_d} = {isa_pkg::alu_or, isa_pkg::sel_logic};
                imm_form      = 1'b1;
                imm_d         = {imm16, 16'h0};
            end
            isa_pkg::op_addi: begin
                {op_d, sel_d} = {isa_pkg::alu_addi, isa_pkg::sel_arith};
                imm_form      = 1'b1;
                imm_d         = {{16{imm16[15]}}, imm16};
            end
            isa_pkg::op_addiu: begin
                {op_d, sel_d} = {isa_pkg::alu_addiu, isa_pkg::sel_arith};
                imm_form      = 1'b1;
                imm_d         = {{16{imm16[15]}}, imm16};
            end
            isa_pkg::op_slti: begin
                {op_d, sel_d} = {isa_pkg::alu_slt, isa_pkg::sel_arith};
                imm_form      = 1'b1;
                imm_d         = {{16{imm16[15]}}, imm16};
            end
            isa_pkg::op_sltiu: begin
                {op_d, sel_d} = {isa_pkg::alu_sltu, isa_pkg::sel_arith};
                imm_form      = 1'b1;
                imm_d         = {{16{imm16[15]}}, imm16};
            end
            default: begin
            end
        endcase
    end

    // reserved fields must be zero
    assign reg_ok   = reg_form && (shamt == '0);
    assign shift_ok = shift_form && (rs == '0);
    assign legal    = reg_ok || shift_ok || imm_form;

    assign ctrl.alu_op  = legal ? op_d : isa_pkg::alu_nop;
    assign ctrl.alu_sel = legal ? sel_d : isa_pkg::sel_nop;
    assign ctrl.dest    = imm_form ? rt : rd;
    assign ctrl.wreg    = legal;
    assign ctrl.illegal = !legal;

    assign rd1.re   = reg_ok || imm_form;
    assign rd1.addr = rs;
    assign rd2.re   = reg_ok || shift_ok;
    assign rd2.addr = rt;

    // shamt goes out on src1 through the immediate path
    assign imm = shift_ok ? {27'h0, shamt} : imm_d;

    illegal_quiet: assert final (!ctrl.illegal || (!ctrl.wreg && !rd1.re && !rd2.re));

endmodule

`default_nettype wire

// ==== hdl/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    // data path widths
    localparam int word_w     = 32;
    localparam int reg_addr_w = 5;

    typedef logic [word_w-1:0]     word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // instruction field positions
    localparam int op_lsb  = 26;
    localparam int rs_lsb  = 21;
    localparam int rt_lsb  = 16;
    localparam int rd_lsb  = 11;
    localparam int sa_lsb  = 6;
    localparam int fn_lsb  = 0;
    localparam int op_w    = 6;
    localparam int imm_w   = 16;

    // primary opcodes
    localparam logic [op_w-1:0] op_special = 6'b000000;
    localparam logic [op_w-1:0] op_addi    = 6'b001000;
    localparam logic [op_w-1:0] op_addiu   = 6'b001001;
    localparam logic [op_w-1:0] op_slti    = 6'b001010;
    localparam logic [op_w-1:0] op_sltiu   = 6'b001011;
    localparam logic [op_w-1:0] op_andi    = 6'b001100;
    localparam logic [op_w-1:0] op_ori     = 6'b001101;
    localparam logic [op_w-1:0] op_xori    = 6'b001110;
    localparam logic [op_w-1:0] op_lui     = 6'b001111;

    // function codes under SPECIAL
    localparam logic [op_w-1:0] fn_sll  = 6'b000000;
    localparam logic [op_w-1:0] fn_srl  = 6'b000010;
    localparam logic [op_w-1:0] fn_sra  = 6'b000011;
    localparam logic [op_w-1:0] fn_sllv = 6'b000100;
    localparam logic [op_w-1:0] fn_srlv = 6'b000110;
    localparam logic [op_w-1:0] fn_srav = 6'b000111;
    localparam logic [op_w-1:0] fn_add  = 6'b100000;
    localparam logic [op_w-1:0] fn_addu = 6'b100001;
    localparam logic [op_w-1:0] fn_sub  = 6'b100010;
    localparam logic [op_w-1:0] fn_subu = 6'b100011;
    localparam logic [op_w-1:0] fn_and  = 6'b100100;
    localparam logic [op_w-1:0] fn_or   = 6'b100101;
    localparam logic [op_w-1:0] fn_xor  = 6'b100110;
    localparam logic [op_w-1:0] fn_nor  = 6'b100111;
    localparam logic [op_w-1:0] fn_slt  = 6'b101010;
    localparam logic [op_w-1:0] fn_sltu = 6'b101011;

    // alu operation codes in the encoding the execute stage expects
    typedef enum logic [7:0] {
        alu_nop   = 8'b0000_0000,
        alu_srl   = 8'b0000_0010,
        alu_sra   = 8'b0000_0011,
        alu_add   = 8'b0010_0000,
        alu_addu  = 8'b0010_0001,
        alu_sub   = 8'b0010_0010,
        alu_subu  = 8'b0010_0011,
        alu_and   = 8'b0010_0100,
        alu_or    = 8'b0010_0101,
        alu_xor   = 8'b0010_0110,
        alu_nor   = 8'b0010_0111,
        alu_slt   = 8'b0010_1010,
        alu_sltu  = 8'b0010_1011,
        alu_addi  = 8'b0101_0101,
        alu_addiu = 8'b0101_0110,
        alu_sll   = 8'b0111_1100
    } alu_op_e;

    // result class
    typedef enum logic [2:0] {
        sel_nop   = 3'b000,
        sel_logic = 3'b001,
        sel_shift = 3'b010,
        sel_arith = 3'b100
    } alu_sel_e;

endpackage

`default_nettype wire

// ==== hdl/operand_select.sv ====
`timescale 1ns/1ns
`default_nettype none

module operand_select (
    input  pipe_pkg::rf_read_t rd,
    input  isa_pkg::word_t     rf_data,
    input  isa_pkg::word_t     imm,
    input  pipe_pkg::fwd_t     ex_fwd,
    input  pipe_pkg::fwd_t     mem_fwd,
    output isa_pkg::word_t     operand
);

    logic ex_hit;
    logic mem_hit;

    // register 0 is forwarded like any other
    assign ex_hit  = ex_fwd.we && (ex_fwd.addr == rd.addr);
    assign mem_hit = mem_fwd.we && (mem_fwd.addr == rd.addr);

    always_comb begin
        if (!rd.re) begin
            operand = imm;
        end else if (ex_hit) begin
            // youngest result wins
            operand = ex_fwd.data;
        end else if (mem_hit) begin
            operand = mem_fwd.data;
        end else begin
            operand = rf_data;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

    // fetch bundle into decode
    typedef struct packed {
        isa_pkg::word_t pc;
        isa_pkg::word_t inst;
    } fetch_t;

    // one register file read port
    typedef struct packed {
        logic               re;
        isa_pkg::reg_addr_t addr;
    } rf_read_t;

    // write-back source seen by forwarding
    typedef struct packed {
        logic               we;
        isa_pkg::reg_addr_t addr;
        isa_pkg::word_t     data;
    } fwd_t;

    // decoded control fields
    typedef struct packed {
        isa_pkg::alu_op_e   alu_op;
        isa_pkg::alu_sel_e  alu_sel;
        isa_pkg::reg_addr_t dest;
        logic               wreg;
        logic               illegal;
    } dec_ctrl_t;

    // bundle handed to execute
    typedef struct packed {
        dec_ctrl_t      ctrl;
        isa_pkg::word_t pc;
        isa_pkg::word_t src1;
        isa_pkg::word_t src2;
    } decoded_t;

endpackage

`default_nettype wire

// ==== sim/tb_decode_checks.svh ====
`ifndef tb_decode_checks_svh
`define tb_decode_checks_svh

// every differing field is listed before the run stops
task automatic check_ctrl(input pipe_pkg::dec_ctrl_t exp, input pipe_pkg::dec_ctrl_t act);
    int bad;
    bad = 0;
    if (act.alu_op !== exp.alu_op) begin
        $display("[ERROR] %0t issue.ctrl.alu_op expected %h got %h", $time, exp.alu_op,
                 act.alu_op);
        bad++;
    end
    if (act.alu_sel !== exp.alu_sel) begin
        $display("[ERROR] %0t issue.ctrl.alu_sel expected %h got %h", $time, exp.alu_sel,
                 act.alu_sel);
        bad++;
    end
    if (act.dest !== exp.dest) begin
        $display("[ERROR] %0t issue.ctrl.dest expected %0d got %0d", $time, exp.dest, act.dest);
        bad++;
    end
    if (act.wreg !== exp.wreg) begin
        $display("[ERROR] %0t issue.ctrl.wreg expected %b got %b", $time, exp.wreg, act.wreg);
        bad++;
    end
    if (act.illegal !== exp.illegal) begin
        $display("[ERROR] %0t issue.ctrl.illegal expected %b got %b", $time, exp.illegal,
                 act.illegal);
        bad++;
    end
    if (bad != 0) begin
        error_count += bad;
        abort_run();
    end
endtask

task automatic check_word(input string name, input isa_pkg::word_t exp,
                          input isa_pkg::word_t act);
    if (act !== exp) begin
        error_count++;
        $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
        abort_run();
    end
endtask

// register file read request
task automatic check_read(input string name, input pipe_pkg::rf_read_t exp,
                          input pipe_pkg::rf_read_t act);
    if (act !== exp) begin
        error_count++;
        $display("[ERROR] %0t %s expected re %b addr %0d got re %b addr %0d", $time, name,
                 exp.re, exp.addr, act.re, act.addr);
        abort_run();
    end
endtask

// handshake levels
task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        error_count++;
        $display("[ERROR] %0t %s expected %b got %b", $time, name, exp, act);
        abort_run();
    end
endtask

`endif

// ==== sim/tb_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_decode;

    // one table row of stimulus, ack delay and expected bundle
    typedef struct packed {
        isa_pkg::word_t      pc;
        isa_pkg::word_t      inst;
        pipe_pkg::fwd_t      ex_fwd;
        pipe_pkg::fwd_t      mem_fwd;
        logic [2:0]          delay;
        pipe_pkg::dec_ctrl_t ctrl;
        pipe_pkg::rf_read_t  rd1;
        pipe_pkg::rf_read_t  rd2;
        isa_pkg::word_t      src1;
        isa_pkg::word_t      src2;
    } row_t;

    localparam pipe_pkg::fwd_t no_fwd = '0;

    logic               clk;
    logic               arst_n;
    logic               fetch_req;
    logic               fetch_ack;
    pipe_pkg::fetch_t   fetch;
    pipe_pkg::rf_read_t rf_rd1;
    pipe_pkg::rf_read_t rf_rd2;
    isa_pkg::word_t     rf_data1;
    isa_pkg::word_t     rf_data2;
    pipe_pkg::fwd_t     ex_fwd;
    pipe_pkg::fwd_t     mem_fwd;
    logic               issue_req;
    logic               issue_ack;
    pipe_pkg::decoded_t issue;

    row_t rows[$];
    int   seed;
    int   error_count;
    int   cycle_count;
    int   cycle_limit;

    decode_top dut0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .fetch_req (fetch_req),
        .fetch_ack (fetch_ack),
        .fetch     (fetch),
        .rf_rd1    (rf_rd1),
        .rf_data1  (rf_data1),
        .rf_rd2    (rf_rd2),
        .rf_data2  (rf_data2),
        .ex_fwd    (ex_fwd),
        .mem_fwd   (mem_fwd),
        .issue_req (issue_req),
        .issue_ack (issue_ack),
        .issue     (issue)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // register file model returns the register number in every byte plus an offset
    function automatic isa_pkg::word_t rf_value(input int addr);
        logic [7:0] b;
        b = {3'b000, addr[4:0]};
        return {b, b, b, b} + 32'h0100_0000;
    endfunction

    assign rf_data1 = rf_value(int'(rf_rd1.addr));
    assign rf_data2 = rf_value(int'(rf_rd2.addr));

    function automatic isa_pkg::word_t r_inst(input int rs, input int rt, input int rd,
                                              input int sa, input logic [5:0] fn);
        return {isa_pkg::op_special, rs[4:0], rt[4:0], rd[4:0], sa[4:0], fn};
    endfunction

    function automatic isa_pkg::word_t i_inst(input logic [5:0] op, input int rs, input int rt,
                                              input logic [15:0] imm);
        return {op, rs[4:0], rt[4:0], imm};
    endfunction

    function automatic pipe_pkg::fwd_t mk_fwd(input logic we, input int addr,
                                              input isa_pkg::word_t data);
        pipe_pkg::fwd_t f;
        f.we   = we;
        f.addr = addr[4:0];
        f.data = data;
        return f;
    endfunction

    task automatic abort_run();
        $display("TB FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic add_row(input isa_pkg::word_t inst, input pipe_pkg::fwd_t exf,
                           input pipe_pkg::fwd_t memf, input isa_pkg::alu_op_e op,
                           input isa_pkg::alu_sel_e sel, input int dest, input logic ill,
                           input logic [1:0] reads, input isa_pkg::word_t s1,
                           input isa_pkg::word_t s2);
        row_t r;
        int   draw;
        draw             = $random(seed);
        r.pc             = 32'h0040_0000 + rows.size() * 4;
        r.inst           = inst;
        r.ex_fwd         = exf;
        r.mem_fwd        = memf;
        r.delay          = draw[2:0];
        r.ctrl.alu_op    = op;
        r.ctrl.alu_sel   = sel;
        r.ctrl.dest      = dest[4:0];
        r.ctrl.wreg      = !ill;
        r.ctrl.illegal   = ill;
        // read ports always address rs and rt
        r.rd1.re         = reads[1];
        r.rd1.addr       = inst[isa_pkg::rs_lsb +: isa_pkg::reg_addr_w];
        r.rd2.re         = reads[0];
        r.rd2.addr       = inst[isa_pkg::rt_lsb +: isa_pkg::reg_addr_w];
        r.src1           = s1;
        r.src2           = s2;
        rows.push_back(r);
    endtask

    task automatic build_table();
        add_row(r_inst(1, 2, 3, 0, isa_pkg::fn_and), no_fwd, no_fwd,
            isa_pkg::alu_and, isa_pkg::sel_logic, 3, 1'b0, 2'b11, rf_value(1), rf_value(2));
        add_row(r_inst(4, 5, 6, 0, isa_pkg::fn_xor), no_fwd, no_fwd,
            isa_pkg::alu_xor, isa_pkg::sel_logic, 6, 1'b0, 2'b11, rf_value(4), rf_value(5));
        add_row(r_inst(7, 8, 9, 0, isa_pkg::fn_nor), no_fwd, no_fwd,
            isa_pkg::alu_nor, isa_pkg::sel_logic, 9, 1'b0, 2'b11, rf_value(7), rf_value(8));
        add_row(r_inst(10, 11, 12, 0, isa_pkg::fn_sllv), no_fwd, no_fwd,
            isa_pkg::alu_sll, isa_pkg::sel_shift, 12, 1'b0, 2'b11, rf_value(10), rf_value(11));
        add_row(r_inst(19, 20, 21, 0, isa_pkg::fn_srlv), no_fwd, no_fwd,
            isa_pkg::alu_srl, isa_pkg::sel_shift, 21, 1'b0, 2'b11, rf_value(19), rf_value(20));
        add_row(r_inst(13, 14, 15, 0, isa_pkg::fn_srav), no_fwd, no_fwd,
            isa_pkg::alu_sra, isa_pkg::sel_shift, 15, 1'b0, 2'b11, rf_value(13), rf_value(14));
        add_row(r_inst(16, 17, 18, 0, isa_pkg::fn_addu), no_fwd, no_fwd,
            isa_pkg::alu_addu, isa_pkg::sel_arith, 18, 1'b0, 2'b11, rf_value(16), rf_value(17));
        add_row(r_inst(28, 29, 30, 0, isa_pkg::fn_subu), no_fwd, no_fwd,
            isa_pkg::alu_subu, isa_pkg::sel_arith, 30, 1'b0, 2'b11, rf_value(28), rf_value(29));
        add_row(r_inst(22, 23, 24, 0, isa_pkg::fn_slt), no_fwd, no_fwd,
            isa_pkg::alu_slt, isa_pkg::sel_arith, 24, 1'b0, 2'b11, rf_value(22), rf_value(23));
        add_row(r_inst(25, 26, 27, 0, isa_pkg::fn_sltu), no_fwd, no_fwd,
            isa_pkg::alu_sltu, isa_pkg::sel_arith, 27, 1'b0, 2'b11, rf_value(25), rf_value(26));
        // immediate forms write rt
        add_row(i_inst(isa_pkg::op_andi, 2, 9, 16'hf0f0), no_fwd, no_fwd,
            isa_pkg::alu_and, isa_pkg::sel_logic, 9, 1'b0, 2'b10, rf_value(2), 32'h0000_f0f0);
        add_row(i_inst(isa_pkg::op_ori, 3, 10, 16'h8001), no_fwd, no_fwd,
            isa_pkg::alu_or, isa_pkg::sel_logic, 10, 1'b0, 2'b10, rf_value(3), 32'h0000_8001);
        add_row(i_inst(isa_pkg::op_xori, 4, 11, 16'hffff), no_fwd, no_fwd,
            isa_pkg::alu_xor, isa_pkg::sel_logic, 11, 1'b0, 2'b10, rf_value(4), 32'h0000_ffff);
        add_row(i_inst(isa_pkg::op_lui, 0, 12, 16'h1234), no_fwd, no_fwd,
            isa_pkg::alu_or, isa_pkg::sel_logic, 12, 1'b0, 2'b10, rf_value(0), 32'h1234_0000);
        add_row(i_inst(isa_pkg::op_addi, 5, 13, 16'hfff6), no_fwd, no_fwd,
            isa_pkg::alu_addi, isa_pkg::sel_arith, 13, 1'b0, 2'b10, rf_value(5), 32'hffff_fff6);
        add_row(i_inst(isa_pkg::op_addiu, 6, 14, 16'h8000), no_fwd, no_fwd,
            isa_pkg::alu_addiu, isa_pkg::sel_arith, 14, 1'b0, 2'b10, rf_value(6), 32'hffff_8000);
        add_row(i_inst(isa_pkg::op_slti, 7, 15, 16'hff00), no_fwd, no_fwd,
            isa_pkg::alu_slt, isa_pkg::sel_arith, 15, 1'b0, 2'b10, rf_value(7), 32'hffff_ff00);
        add_row(i_inst(isa_pkg::op_sltiu, 8, 16, 16'h8123), no_fwd, no_fwd,
            isa_pkg::alu_sltu, isa_pkg::sel_arith, 16, 1'b0, 2'b10, rf_value(8), 32'hffff_8123);
        // shamt shifts put the shift amount on src1
        add_row(r_inst(0, 17, 18, 5, isa_pkg::fn_sll), no_fwd, no_fwd,
            isa_pkg::alu_sll, isa_pkg::sel_shift, 18, 1'b0, 2'b01, 32'd5, rf_value(17));
        add_row(r_inst(0, 19, 20, 31, isa_pkg::fn_srl), no_fwd, no_fwd,
            isa_pkg::alu_srl, isa_pkg::sel_shift, 20, 1'b0, 2'b01, 32'd31, rf_value(19));
        add_row(r_inst(0, 21, 22, 1, isa_pkg::fn_sra), no_fwd, no_fwd,
            isa_pkg::alu_sra, isa_pkg::sel_shift, 22, 1'b0, 2'b01, 32'd1, rf_value(21));
        // forwarding with ex over mem, then mem alone, then write enables low
        add_row(r_inst(3, 4, 5, 0, isa_pkg::fn_add), mk_fwd(1'b1, 3, 32'hdead_0001),
            mk_fwd(1'b1, 3, 32'hbeef_0002), isa_pkg::alu_add, isa_pkg::sel_arith, 5, 1'b0,
            2'b11, 32'hdead_0001, rf_value(4));
        add_row(r_inst(6, 7, 8, 0, isa_pkg::fn_sub), mk_fwd(1'b1, 9, 32'h1111_2222),
            mk_fwd(1'b1, 7, 32'hcafe_0003), isa_pkg::alu_sub, isa_pkg::sel_arith, 8, 1'b0,
            2'b11, rf_value(6), 32'hcafe_0003);
        add_row(r_inst(10, 11, 12, 0, isa_pkg::fn_or), mk_fwd(1'b0, 10, 32'h5555_aaaa),
            mk_fwd(1'b0, 11, 32'haaaa_5555), isa_pkg::alu_or, isa_pkg::sel_logic, 12, 1'b0,
            2'b11, rf_value(10), rf_value(11));
        // dropped encodings mult, clz, mfhi and sll with rs set
        add_row(r_inst(1, 2, 0, 0, 6'b011000), no_fwd, no_fwd,
            isa_pkg::alu_nop, isa_pkg::sel_nop, 0, 1'b1, 2'b00, 32'h0, 32'h0);
        add_row(32'h7060_2020, no_fwd, no_fwd,
            isa_pkg::alu_nop, isa_pkg::sel_nop, 4, 1'b1, 2'b00, 32'h0, 32'h0);
        add_row(r_inst(0, 0, 5, 0, 6'b010000), no_fwd, no_fwd,
            isa_pkg::alu_nop, isa_pkg::sel_nop, 5, 1'b1, 2'b00, 32'h0, 32'h0);
        add_row(r_inst(1, 2, 3, 4, isa_pkg::fn_sll), no_fwd, no_fwd,
            isa_pkg::alu_nop, isa_pkg::sel_nop, 3, 1'b1, 2'b00, 32'h0, 32'h0);
    endtask

    task automatic run_row(input row_t r);
        check_bit("fetch_ack before request", 1'b0, fetch_ack);
        fetch.pc   = r.pc;
        fetch.inst = r.inst;
        ex_fwd     = r.ex_fwd;
        mem_fwd    = r.mem_fwd;
        fetch_req  = 1'b1;
        do begin
            @(negedge clk);
        end while (!fetch_ack);
        fetch_req = 1'b0;
        do begin
            @(negedge clk);
        end while (fetch_ack);
        while (!issue_req) begin
            @(negedge clk);
        end
        check_ctrl(r.ctrl, issue.ctrl);
        check_word("issue.pc", r.pc, issue.pc);
        check_word("issue.src1", r.src1, issue.src1);
        check_word("issue.src2", r.src2, issue.src2);
        check_read("rf_rd1", r.rd1, rf_rd1);
        check_read("rf_rd2", r.rd2, rf_rd2);
        // bundle has to wait in place while ack is held back
        repeat (r.delay) begin
            @(negedge clk);
            check_bit("issue_req under back-pressure", 1'b1, issue_req);
        end
        check_word("issue.pc after delay", r.pc, issue.pc);
        issue_ack = 1'b1;
        do begin
            @(negedge clk);
        end while (issue_req);
        issue_ack = 1'b0;
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("timeout: table not finished after %0d cycles", cycle_count);
            abort_run();
        end
    end

    initial begin
        seed        = 32'h00e8_e0e1;
        error_count = 0;
        cycle_count = 0;
        cycle_limit = 0;
        arst_n      = 1'b0;
        fetch_req   = 1'b0;
        fetch       = '0;
        ex_fwd      = '0;
        mem_fwd     = '0;
        issue_ack   = 1'b0;
        build_table();
        cycle_limit = rows.size() * 20 + 50;
        repeat (4) @(negedge clk);
        arst_n = 1'b1;
        check_bit("fetch_ack after reset", 1'b0, fetch_ack);
        check_bit("issue_req after reset", 1'b0, issue_req);
        foreach (rows[i]) begin
            run_row(rows[i]);
        end
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    `include "tb_decode_checks.svh"

endmodule

`default_nettype wire
